/* Bender.yml */
package:
  name: board_io

sources:
  - source/board_pkg.sv
  - source/reg_bus_if.sv
  - source/input_debouncer.sv
  - source/axi_lite_slave.sv
  - source/board_io_regs.sv
  - source/seven_seg_scanner.sv
  - source/board_io_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/board_io_tb.sv

/* build.f */
+incdir+tb
source/board_pkg.sv
source/reg_bus_if.sv
source/input_debouncer.sv
source/axi_lite_slave.sv
source/board_io_regs.sv
source/seven_seg_scanner.sv
source/board_io_top.sv
tb/board_io_tb.sv

/* source/axi_lite_slave.sv */
`timescale 1ns/1ns

module axi_lite_slave import board_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,

    input  addr_t  s_axi_awaddr,
    input  logic   s_axi_awvalid,
    output logic   s_axi_awready,
    input  data_t  s_axi_wdata,
    input  strb_t  s_axi_wstrb,
    input  logic   s_axi_wvalid,
    output logic   s_axi_wready,
    output resp_t  s_axi_bresp,
    output logic   s_axi_bvalid,
    input  logic   s_axi_bready,

    input  addr_t  s_axi_araddr,
    input  logic   s_axi_arvalid,
    output logic   s_axi_arready,
    output data_t  s_axi_rdata,
    output resp_t  s_axi_rresp,
    output logic   s_axi_rvalid,
    input  logic   s_axi_rready,

    reg_bus_if.host bus
);

    logic  wr_ready_q;
    logic  rd_ready_q;
    logic  bvalid_q;
    logic  rvalid_q;
    resp_t bresp_q;
    resp_t rresp_q;
    data_t rdata_q;

    logic  wr_start;
    logic  rd_start;
    logic  wr_fire;
    logic  rd_fire;

    // **************************************************
    // accept rules
    // **************************************************

    // aw and w are taken together, only with no response held.
    assign wr_start = s_axi_awvalid & s_axi_wvalid & ~bvalid_q & ~wr_ready_q;
    // a pending write wins, so the two enables never overlap.
    assign rd_start = s_axi_arvalid & ~rvalid_q & ~rd_ready_q & ~wr_start;

    assign wr_fire = wr_ready_q & s_axi_awvalid & s_axi_wvalid;
    assign rd_fire = rd_ready_q & s_axi_arvalid;

    assign bus.wr_en   = wr_fire;
    assign bus.wr_addr = s_axi_awaddr;
    assign bus.wr_data = s_axi_wdata;
    assign bus.wr_strb = s_axi_wstrb;
    assign bus.rd_en   = rd_fire;
    assign bus.rd_addr = s_axi_araddr;

    // **************************************************
    // ready, valid and response registers
    // **************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ready_q <= 1'b0;
            rd_ready_q <= 1'b0;
            bvalid_q   <= 1'b0;
            rvalid_q   <= 1'b0;
            bresp_q    <= OKAY;
            rresp_q    <= OKAY;
        end else begin
            wr_ready_q <= wr_start; // one-cycle pulse.
            rd_ready_q <= rd_start;

            if (wr_fire) begin
                bvalid_q <= 1'b1;
                bresp_q  <= bus.wr_err ? SLVERR : OKAY;
            end else if (bvalid_q && s_axi_bready) begin
                bvalid_q <= 1'b0;
            end

            if (rd_fire) begin
                rvalid_q <= 1'b1;
                rresp_q  <= bus.rd_err ? SLVERR : OKAY;
            end else if (rvalid_q && s_axi_rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata_q <= bus.rd_data; // zero on error.
        end
    end

    assign s_axi_awready = wr_ready_q;
    assign s_axi_wready  = wr_ready_q;
    assign s_axi_bvalid  = bvalid_q;
    assign s_axi_bresp   = bresp_q;
    assign s_axi_arready = rd_ready_q;
    assign s_axi_rvalid  = rvalid_q;
    assign s_axi_rresp   = rresp_q;
    assign s_axi_rdata   = rdata_q;

endmodule

/* source/board_io_regs.sv */
`timescale 1ns/1ns

module board_io_regs import board_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    reg_bus_if.regs               bus,

    input  switch_t               switches,
    input  button_t               buttons,

    output red_led_t              red_led,
    output green_led_t            green_led,
    output data_t                 seg_value,
    output logic [NUM_DIGITS-1:0] seg_enable
);

    red_led_t              red_q;
    green_led_t            green_q;
    data_t                 seg_value_q;
    logic [NUM_DIGITS-1:0] seg_enable_q;

    data_t wr_current;
    data_t wr_merged;
    logic  wr_mapped;

    function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t strb);
        data_t result;
        result = old_val;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return result;
    endfunction

    // **************************************************
    // write decode
    // **************************************************

    always_comb begin
        wr_mapped  = 1'b1;
        wr_current = '0;
        case (bus.wr_addr)
            RED_LEDS:   wr_current = data_t'(red_q);
            GREEN_LEDS: wr_current = data_t'(green_q);
            SEG_VALUE:  wr_current = seg_value_q;
            SEG_ENABLE: wr_current = data_t'(seg_enable_q);
            default:    wr_mapped  = 1'b0; // unmapped or read-only.
        endcase
    end

    assign wr_merged  = merge_bytes(wr_current, bus.wr_data, bus.wr_strb);
    assign bus.wr_err = bus.wr_en & ~wr_mapped;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            red_q        <= '0;
            green_q      <= '0;
            seg_value_q  <= '0;
            seg_enable_q <= '0;
        end else if (bus.wr_en) begin
            case (bus.wr_addr)
                RED_LEDS:   red_q        <= red_led_t'(wr_merged);
                GREEN_LEDS: green_q      <= green_led_t'(wr_merged);
                SEG_VALUE:  seg_value_q  <= wr_merged;
                SEG_ENABLE: seg_enable_q <= wr_merged[NUM_DIGITS-1:0];
                default:    ;
            endcase
        end
    end

    // **************************************************
    // read mux
    // **************************************************

    always_comb begin
        bus.rd_data = '0;
        bus.rd_err  = bus.rd_en;
        if (bus.rd_en) begin
            bus.rd_err = 1'b0;
            case (bus.rd_addr)
                SWITCHES:   bus.rd_data = data_t'(switches);
                BUTTONS:    bus.rd_data = data_t'(buttons);
                RED_LEDS:   bus.rd_data = data_t'(red_q);
                GREEN_LEDS: bus.rd_data = data_t'(green_q);
                SEG_VALUE:  bus.rd_data = seg_value_q;
                SEG_ENABLE: bus.rd_data = data_t'(seg_enable_q);
                default:    bus.rd_err  = 1'b1;
            endcase
        end
    end

    assign red_led    = red_q;
    assign green_led  = green_q;
    assign seg_value  = seg_value_q;
    assign seg_enable = seg_enable_q;

endmodule

/* source/board_io_top.sv */
`timescale 1ns/1ns

module board_io_top import board_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 500000,
    parameter int SCAN_DIVIDE     = 12500
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  switch_t               sw,
    input  button_t               btn,

    output red_led_t              red_led,
    output green_led_t            green_led,
    output seg_t                  seg,
    output logic [NUM_DIGITS-1:0] an,

    input  addr_t                 s_axi_awaddr,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,
    input  data_t                 s_axi_wdata,
    input  strb_t                 s_axi_wstrb,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,
    output resp_t                 s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,
    input  addr_t                 s_axi_araddr,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,
    output data_t                 s_axi_rdata,
    output resp_t                 s_axi_rresp,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready
);

    switch_t               sw_db;
    button_t               btn_db;
    data_t                 seg_value;
    logic [NUM_DIGITS-1:0] seg_enable;

    reg_bus_if reg_bus ();

    // **************************************************
    // input conditioning
    // **************************************************

    input_debouncer
    # (
        .DEBOUNCE_CYCLES ( DEBOUNCE_CYCLES ),
        .payload_t       ( switch_t        )
    )
    switch_debouncer
    (
        .clk    ( clk   ),
        .rst_n  ( rst_n ),
        .raw    ( sw    ),
        .stable ( sw_db )
    );

    input_debouncer
    # (
        .DEBOUNCE_CYCLES ( DEBOUNCE_CYCLES ),
        .payload_t       ( button_t        )
    )
    button_debouncer
    (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .raw    ( btn    ),
        .stable ( btn_db )
    );

    // **************************************************
    // bus-facing system block
    // **************************************************

    axi_lite_slave axi_lite_slave
    (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .s_axi_awaddr  ( s_axi_awaddr  ),
        .s_axi_awvalid ( s_axi_awvalid ),
        .s_axi_awready ( s_axi_awready ),
        .s_axi_wdata   ( s_axi_wdata   ),
        .s_axi_wstrb   ( s_axi_wstrb   ),
        .s_axi_wvalid  ( s_axi_wvalid  ),
        .s_axi_wready  ( s_axi_wready  ),
        .s_axi_bresp   ( s_axi_bresp   ),
        .s_axi_bvalid  ( s_axi_bvalid  ),
        .s_axi_bready  ( s_axi_bready  ),
        .s_axi_araddr  ( s_axi_araddr  ),
        .s_axi_arvalid ( s_axi_arvalid ),
        .s_axi_arready ( s_axi_arready ),
        .s_axi_rdata   ( s_axi_rdata   ),
        .s_axi_rresp   ( s_axi_rresp   ),
        .s_axi_rvalid  ( s_axi_rvalid  ),
        .s_axi_rready  ( s_axi_rready  ),
        .bus           ( reg_bus.host  )
    );

    board_io_regs board_io_regs
    (
        .clk        ( clk          ),
        .rst_n      ( rst_n        ),
        .bus        ( reg_bus.regs ),
        .switches   ( sw_db        ),
        .buttons    ( btn_db       ),
        .red_led    ( red_led      ),
        .green_led  ( green_led    ),
        .seg_value  ( seg_value    ),
        .seg_enable ( seg_enable   )
    );

    // display drive.
    seven_seg_scanner
    # (.SCAN_DIVIDE ( SCAN_DIVIDE ))
    seven_seg_scanner
    (
        .clk    ( clk        ),
        .rst_n  ( rst_n      ),
        .value  ( seg_value  ),
        .enable ( seg_enable ),
        .seg    ( seg        ),
        .an     ( an         )
    );

endmodule

/* source/board_pkg.sv */
package board_pkg;

    // bus words.
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  addr_t;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } resp_t;

    // register byte offsets.
    typedef enum logic [7:0] {
        SWITCHES   = 8'h00, // read-only.
        BUTTONS    = 8'h04, // read-only.
        RED_LEDS   = 8'h08,
        GREEN_LEDS = 8'h0C,
        SEG_VALUE  = 8'h10,
        SEG_ENABLE = 8'h14
    } reg_addr_e;

    typedef logic [15:0] switch_t;

    // same bit order as the board pins with up as the msb.
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic centre;
        logic right;
    } button_t;

    typedef logic [17:0] red_led_t; // board shows the low 16.
    typedef logic [8:0]  green_led_t;

    // active-low segments ca..cg then dp.
    typedef logic [7:0] seg_t;

    localparam int NUM_DIGITS = 8;

endpackage

/* source/input_debouncer.sv */
`timescale 1ns/1ns

module input_debouncer #(
    parameter int  DEBOUNCE_CYCLES = 8,
    parameter type payload_t       = logic [15:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t raw,
    output payload_t stable
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    payload_t   sync_q1;
    payload_t   sync_q2;
    payload_t   prev_q;
    payload_t   stable_q;
    logic [CNT_W-1:0] count_q;

    // two-flop synchroniser.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= raw;
            sync_q2 <= sync_q1;
        end
    end

    // count cycles since the last change of the synchronised value.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_q   <= '0;
            count_q  <= '0;
            stable_q <= '0;
        end else begin
            prev_q <= sync_q2;
            if (sync_q2 != prev_q) begin
                count_q <= CNT_W'(1); // the change cycle counts as one.
            end else if (count_q != CNT_W'(DEBOUNCE_CYCLES)) begin
                count_q <= count_q + 1'b1;
            end

            if (count_q == CNT_W'(DEBOUNCE_CYCLES)) begin
                stable_q <= prev_q;
            end
        end
    end

    assign stable = stable_q;

endmodule

/* source/reg_bus_if.sv */
`timescale 1ns/1ns

interface reg_bus_if import board_pkg::*; ();

    // write side.
    logic  wr_en;
    addr_t wr_addr;
    data_t wr_data;
    strb_t wr_strb;
    logic  wr_err;

    // read side.
    logic  rd_en;
    addr_t rd_addr;
    data_t rd_data;
    logic  rd_err;

    modport host (
        output wr_en, wr_addr, wr_data, wr_strb,
        input  wr_err,
        output rd_en, rd_addr,
        input  rd_data, rd_err
    );

    modport regs (
        input  wr_en, wr_addr, wr_data, wr_strb,
        output wr_err,
        input  rd_en, rd_addr,
        output rd_data, rd_err
    );

endinterface

/* source/seven_seg_scanner.sv */
`timescale 1ns/1ns

module seven_seg_scanner import board_pkg::*; #(
    parameter int SCAN_DIVIDE = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  data_t                 value,
    input  logic [NUM_DIGITS-1:0] enable,
    output seg_t                  seg,
    output logic [NUM_DIGITS-1:0] an
);

    localparam int PRE_W = (SCAN_DIVIDE > 1) ? $clog2(SCAN_DIVIDE) : 1;
    localparam int IDX_W = $clog2(NUM_DIGITS);

    logic [PRE_W-1:0]      pre_q;
    logic [IDX_W-1:0]      digit_q;
    logic [3:0]            nibble;
    seg_t                  seg_q;
    logic [NUM_DIGITS-1:0] an_q;

    // segments a..g, active high.
    function automatic logic [6:0] hex_to_abcdefg(logic [3:0] hex);
        case (hex)
            4'h0: return 7'h7E;
            4'h1: return 7'h30;
            4'h2: return 7'h6D;
            4'h3: return 7'h79;
            4'h4: return 7'h33;
            4'h5: return 7'h5B;
            4'h6: return 7'h5F;
            4'h7: return 7'h70;
            4'h8: return 7'h7F;
            4'h9: return 7'h7B;
            4'hA: return 7'h77;
            4'hB: return 7'h1F;
            4'hC: return 7'h4E;
            4'hD: return 7'h3D;
            4'hE: return 7'h4F;
            default: return 7'h47;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_q   <= '0;
            digit_q <= '0;
        end else if (pre_q == PRE_W'(SCAN_DIVIDE - 1)) begin
            pre_q   <= '0;
            digit_q <= (digit_q == IDX_W'(NUM_DIGITS - 1)) ? '0 : digit_q + 1'b1;
        end else begin
            pre_q <= pre_q + 1'b1;
        end
    end

    assign nibble = value[4*digit_q +: 4];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg_q <= '1;
            an_q  <= '1;
        end else if (enable[digit_q]) begin
            seg_q <= {~hex_to_abcdefg(nibble), 1'b1}; // dp off.
            an_q  <= ~(NUM_DIGITS'(1) << digit_q);
        end else begin
            seg_q <= '1; // blanked digit.
            an_q  <= '1;
        end
    end

    assign seg = seg_q;
    assign an  = an_q;

endmodule

/* tb/board_io_checks.svh */
`ifndef BOARD_IO_CHECKS_SVH
`define BOARD_IO_CHECKS_SVH

// **************************************************
// compare tasks
// **************************************************

task automatic report_mismatch(input string name, input string got, input string expected);
    abort_run($sformatf("MISMATCH at %0t ns: %s got %s expected %s",
                        $time, name, got, expected));
endtask

task automatic check_data(input string name, input data_t got, input data_t expected);
    if (got !== expected) begin
        report_mismatch(name, $sformatf("%h", got), $sformatf("%h", expected));
    end
endtask

task automatic check_resp(input string name, input resp_t got, input resp_t expected);
    if (got !== expected) begin
        report_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", expected));
    end
endtask

task automatic check_seg(input string name, input seg_t got, input seg_t expected);
    if (got !== expected) begin
        report_mismatch(name, $sformatf("%b", got), $sformatf("%b", expected));
    end
endtask

task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected) begin
        report_mismatch(name, $sformatf("%b", got), $sformatf("%b", expected));
    end
endtask

// **************************************************
// axi4-lite master
// **************************************************

task automatic write_request(input addr_t addr, input data_t data, input strb_t strb);
    @(posedge clk);
    s_axi_awaddr  <= addr;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= strb;
    s_axi_awvalid <= 1'b1;
    s_axi_wvalid  <= 1'b1;
    do begin
        @(negedge clk);
    end while (!s_axi_awready);
    check_bit("s_axi_wready", s_axi_wready, 1'b1);
    @(posedge clk); // aw and w handshake.
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid  <= 1'b0;
endtask

task automatic write_response(input int hold_cycles, output resp_t resp);
    @(negedge clk);
    check_bit("s_axi_bvalid", s_axi_bvalid, 1'b1); // one cycle after the handshake.
    resp = s_axi_bresp;
    repeat (hold_cycles) begin
        @(negedge clk);
        check_bit("s_axi_bvalid", s_axi_bvalid, 1'b1);
        check_resp("s_axi_bresp", s_axi_bresp, resp);
        check_bit("s_axi_awready", s_axi_awready, 1'b0);
    end
    @(posedge clk);
    s_axi_bready <= 1'b1;
    @(posedge clk);
    s_axi_bready <= 1'b0;
    @(negedge clk);
    check_bit("s_axi_bvalid", s_axi_bvalid, 1'b0);
endtask

task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                         input int hold_cycles, output resp_t resp);
    write_request(addr, data, strb);
    write_response(hold_cycles, resp);
endtask

task automatic read_request(input addr_t addr);
    @(posedge clk);
    s_axi_araddr  <= addr;
    s_axi_arvalid <= 1'b1;
    do begin
        @(negedge clk);
    end while (!s_axi_arready);
    @(posedge clk);
    s_axi_arvalid <= 1'b0;
endtask

task automatic read_response(input int hold_cycles, output data_t data, output resp_t resp);
    @(negedge clk);
    check_bit("s_axi_rvalid", s_axi_rvalid, 1'b1);
    data = s_axi_rdata;
    resp = s_axi_rresp;
    repeat (hold_cycles) begin
        @(negedge clk);
        check_bit("s_axi_rvalid", s_axi_rvalid, 1'b1);
        check_data("s_axi_rdata", s_axi_rdata, data);
        check_resp("s_axi_rresp", s_axi_rresp, resp);
    end
    @(posedge clk);
    s_axi_rready <= 1'b1;
    @(posedge clk);
    s_axi_rready <= 1'b0;
    @(negedge clk);
    check_bit("s_axi_rvalid", s_axi_rvalid, 1'b0);
endtask

task automatic axi_read(input addr_t addr, input int hold_cycles,
                        output data_t data, output resp_t resp);
    read_request(addr);
    read_response(hold_cycles, data, resp);
endtask

`endif

/* tb/board_io_tb.sv */
`timescale 1ns/1ns

module board_io_tb import board_pkg::*; ();

    localparam int CLK_PERIOD      = 4;
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int SCAN_DIVIDE     = 16;

    localparam int N_WRITES  = 40;
    localparam int N_INPUTS  = 10;
    localparam int N_DISPLAY = 4;
    localparam int N_ERRORS  = 8;
    localparam int N_STALLS  = 6;

    // rough cycle budget of the whole sequence.
    localparam int TEST_CYCLES = 20 + N_WRITES * 20
        + N_INPUTS * (3 * DEBOUNCE_CYCLES + 40)
        + N_DISPLAY * (NUM_DIGITS * SCAN_DIVIDE + 40)
        + N_ERRORS * 20 + N_STALLS * 60;

    logic                  clk = 1'b0;
    logic                  rst_n;
    switch_t               sw;
    button_t               btn;
    red_led_t              red_led;
    green_led_t            green_led;
    seg_t                  seg;
    logic [NUM_DIGITS-1:0] an;

    addr_t s_axi_awaddr;
    logic  s_axi_awvalid;
    logic  s_axi_awready;
    data_t s_axi_wdata;
    strb_t s_axi_wstrb;
    logic  s_axi_wvalid;
    logic  s_axi_wready;
    resp_t s_axi_bresp;
    logic  s_axi_bvalid;
    logic  s_axi_bready;
    addr_t s_axi_araddr;
    logic  s_axi_arvalid;
    logic  s_axi_arready;
    data_t s_axi_rdata;
    resp_t s_axi_rresp;
    logic  s_axi_rvalid;
    logic  s_axi_rready;

    data_t                 model_regs [6]; // one word per offset / 4.
    data_t                 lcg_state = 32'd51;
    logic                  scan_on;
    logic [NUM_DIGITS-1:0] seen_digits;

    // lit segments of each hex digit.
    string segment_map [16] = '{"abcdef", "bc", "abdeg", "abcdg", "bcfg", "acdfg",
                                "acdefg", "abc", "abcdefg", "abcdfg", "abcefg", "cdefg",
                                "adef", "bcdeg", "adefg", "aefg"};

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    `include "board_io_checks.svh"

    board_io_top #(
        .DEBOUNCE_CYCLES ( DEBOUNCE_CYCLES ),
        .SCAN_DIVIDE     ( SCAN_DIVIDE     )
    ) dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic data_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]}; // high bits are the better ones.
    endfunction

    function automatic data_t field_mask(input addr_t offset);
        case (offset)
            SWITCHES:   return 32'h0000_FFFF;
            BUTTONS:    return 32'h0000_001F;
            RED_LEDS:   return 32'h0003_FFFF;
            GREEN_LEDS: return 32'h0000_01FF;
            SEG_ENABLE: return 32'h0000_00FF;
            default:    return 32'hFFFF_FFFF;
        endcase
    endfunction

    // **************************************************
    // reference model
    // **************************************************

    function automatic data_t expected_write(input addr_t offset, input data_t old_value,
                                             input data_t data, input strb_t strb);
        data_t result;
        result = old_value;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = data[8*b +: 8];
            end
        end
        return result & field_mask(offset);
    endfunction

    function automatic seg_t segment_pattern(input logic [3:0] nibble);
        seg_t pattern;
        pattern = '1; // dp stays off.
        for (int k = 0; k < segment_map[nibble].len(); k++) begin
            pattern[7 - (segment_map[nibble][k] - 8'h61)] = 1'b0;
        end
        return pattern;
    endfunction

    // display monitor.
    always @(negedge clk) begin : scan_monitor
        int low_count;
        int low_idx;
        if (scan_on) begin
            low_count = 0;
            low_idx   = 0;
            for (int d = 0; d < NUM_DIGITS; d++) begin
                if (!an[d]) begin
                    low_count++;
                    low_idx = d;
                end
            end
            if (low_count == 0) begin
                check_seg("seg (blank)", seg, '1);
            end else begin
                check_bit("an single digit", low_count == 1, 1'b1);
                check_bit("an digit enabled", model_regs[5][low_idx], 1'b1);
                check_seg("seg", seg, segment_pattern(model_regs[4][4*low_idx +: 4]));
                seen_digits[low_idx] = 1'b1;
            end
        end
    end

    initial begin
        #(4 * TEST_CYCLES * CLK_PERIOD);
        abort_run("run timed out before the test sequence finished");
    end

    // **************************************************
    // tests
    // **************************************************

    task automatic read_expect(input addr_t offset, input data_t expected,
                               input resp_t expected_resp);
        data_t rd;
        resp_t resp;
        axi_read(offset, 0, rd, resp);
        check_resp($sformatf("s_axi_rresp @%h", offset), resp, expected_resp);
        check_data($sformatf("s_axi_rdata @%h", offset), rd, expected);
    endtask

    task automatic expect_reset_values();
        @(negedge clk);
        check_data("red_led", data_t'(red_led), '0);
        check_data("green_led", data_t'(green_led), '0);
        check_bit("s_axi_bvalid", s_axi_bvalid, 1'b0);
        check_bit("s_axi_rvalid", s_axi_rvalid, 1'b0);
        check_bit("s_axi_awready", s_axi_awready, 1'b0);
        check_bit("s_axi_arready", s_axi_arready, 1'b0);
        check_data("an", data_t'(an), data_t'({NUM_DIGITS{1'b1}}));
        check_seg("seg", seg, '1);
    endtask

    task automatic write_registers_randomly();
        addr_t offset;
        data_t data;
        strb_t strb;
        resp_t resp;
        int    idx;
        for (int n = 0; n < N_WRITES; n++) begin
            idx    = 2 + int'(next_rand() % 4);
            offset = addr_t'(idx * 4);
            data   = next_rand();
            strb   = strb_t'(next_rand());
            axi_write(offset, data, strb, 0, resp);
            check_resp($sformatf("s_axi_bresp @%h", offset), resp, OKAY);
            model_regs[idx] = expected_write(offset, model_regs[idx], data, strb);
            check_data("red_led", data_t'(red_led), model_regs[2]);
            check_data("green_led", data_t'(green_led), model_regs[3]);
            read_expect(offset, model_regs[idx], OKAY);
        end
    endtask

    task automatic debounce_inputs();
        data_t   word;
        switch_t sw_value;
        button_t btn_value;
        for (int n = 0; n < N_INPUTS; n++) begin
            word      = next_rand();
            sw_value  = word[15:0];
            btn_value = button_t'(word[20:16]);
            @(posedge clk);
            sw  <= sw_value;
            btn <= btn_value;
            repeat (DEBOUNCE_CYCLES + 3) @(posedge clk);
            model_regs[0] = data_t'(sw_value);
            model_regs[1] = data_t'(btn_value);
            read_expect(SWITCHES, model_regs[0], OKAY);
            read_expect(BUTTONS, model_regs[1], OKAY);
            // a short glitch must be filtered out.
            @(posedge clk);
            sw  <= ~sw_value;
            btn <= ~btn_value;
            repeat (DEBOUNCE_CYCLES - 2) @(posedge clk);
            sw  <= sw_value;
            btn <= btn_value;
            // read back while an unfiltered glitch would still show.
            read_expect(SWITCHES, model_regs[0], OKAY);
            read_expect(BUTTONS, model_regs[1], OKAY);
        end
    endtask

    task automatic scan_display();
        data_t value;
        data_t enable;
        resp_t resp;
        for (int n = 0; n < N_DISPLAY; n++) begin
            value  = next_rand();
            enable = next_rand() | (data_t'(1) << (next_rand() % NUM_DIGITS));
            axi_write(SEG_VALUE, value, 4'hF, 0, resp);
            check_resp("s_axi_bresp seg value", resp, OKAY);
            model_regs[4] = expected_write(SEG_VALUE, model_regs[4], value, 4'hF);
            axi_write(SEG_ENABLE, enable, 4'b0001, 0, resp);
            check_resp("s_axi_bresp seg enable", resp, OKAY);
            model_regs[5] = expected_write(SEG_ENABLE, model_regs[5], enable, 4'b0001);
            @(posedge clk);
            seen_digits = '0;
            scan_on     = 1'b1;
            repeat (NUM_DIGITS * SCAN_DIVIDE) @(posedge clk); // one full rotation.
            scan_on = 1'b0;
            check_data("digits shown", data_t'(seen_digits), model_regs[5]);
        end
    endtask

    task automatic provoke_errors();
        addr_t offset;
        resp_t resp;
        for (int n = 0; n < N_ERRORS; n++) begin
            if (n == 0) begin
                offset = SWITCHES;
            end else if (n == 1) begin
                offset = BUTTONS;
            end else begin
                offset = addr_t'(next_rand()) | 8'h18; // past the last register.
            end
            axi_write(offset, next_rand(), strb_t'(next_rand()), 0, resp);
            check_resp($sformatf("s_axi_bresp @%h", offset), resp, SLVERR);
            if (n >= 2) begin
                read_expect(offset, '0, SLVERR);
            end
        end
        for (int r = 0; r < 6; r++) begin
            read_expect(addr_t'(4 * r), model_regs[r], OKAY);
        end
        check_data("red_led", data_t'(red_led), model_regs[2]);
        check_data("green_led", data_t'(green_led), model_regs[3]);
    endtask

    task automatic stall_responses();
        data_t first;
        data_t second;
        data_t rd;
        resp_t resp;
        int    hold;
        for (int n = 0; n < N_STALLS; n++) begin
            first  = next_rand();
            second = next_rand();
            hold   = 1 + int'(next_rand() % 10);
            write_request(GREEN_LEDS, first, 4'hF);
            // second write waits behind the held response.
            s_axi_wdata   <= second;
            s_axi_awvalid <= 1'b1;
            s_axi_wvalid  <= 1'b1;
            write_response(hold, resp);
            check_resp("s_axi_bresp first", resp, OKAY);
            model_regs[3] = expected_write(GREEN_LEDS, model_regs[3], first, 4'hF);
            check_data("green_led", data_t'(green_led), model_regs[3]);
            axi_write(GREEN_LEDS, second, 4'hF, 0, resp);
            check_resp("s_axi_bresp second", resp, OKAY);
            model_regs[3] = expected_write(GREEN_LEDS, model_regs[3], second, 4'hF);
            axi_read(GREEN_LEDS, hold, rd, resp);
            check_resp("s_axi_rresp held", resp, OKAY);
            check_data("s_axi_rdata held", rd, model_regs[3]);
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        sw            = '0;
        btn           = '0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        scan_on       = 1'b0;
        seen_digits   = '0;
        for (int r = 0; r < 6; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        expect_reset_values();
        write_registers_randomly();
        debounce_inputs();
        scan_display();
        provoke_errors();
        stall_responses();

        $display("Testbench passed");
        $finish;
    end

endmodule
